/* Bender.yml */
package:
  name: decode_stage

sources:
  - files:
      - rtl/decodePkg.sv
      - rtl/decodeRd.sv
      - rtl/decodeSources.sv
      - rtl/decodeImmediate.sv
      - rtl/decodeStage.sv
  - target: simulation
    files:
      - sim/decodeStage_props.sv
      - sim/decodeStageTb.sv

/* build.f */
rtl/decodePkg.sv
rtl/decodeRd.sv
rtl/decodeSources.sv
rtl/decodeImmediate.sv
rtl/decodeStage.sv
sim/decodeStage_props.sv
sim/decodeStageTb.sv

/* rtl/decodeImmediate.sv */
// ==================================================
// Purely combinational. Opcodes without an immediate give zero
// ==================================================
`timescale 1ns/10ps
`default_nettype none

module decodeImmediate
	import decodePkg::*;
(
	input  microOpT              instr,
	output logic [IMM_WIDTH-1:0] imm
);

	// ==================================================
	// Raw fields per instruction format
	// ==================================================

	// I-format field, shared by ALU immediates, loads, JSR and CSR
	logic [IMM_I_W-1:0] immI;
	logic [SHAMT_W-1:0] shamt;
	// Store offset is split around the rs1 and rs2 fields
	logic [ST_W-1:0] immSt;
	// Long branch displacement covers everything above rd
	logic [DISP_W-1:0] disp;

	assign immI = instr[IMM_I_MSB:IMM_I_LSB];
	assign shamt = instr[SHAMT_MSB:IMM_I_LSB];
	assign immSt = {instr[IMM_I_MSB:ST_HI_LSB], instr.rd};
	assign disp = instr[IMM_I_MSB:DISP_LSB];

	// ==================================================
	// Format select and extension
	// ==================================================

	always_comb
	begin
		case (instr.opcode)
		OP_ADDI, OP_SUBFI, OP_CMPI, OP_ANDI, OP_ORI, OP_XORI, OP_MULI:
			imm = {{(IMM_WIDTH-IMM_I_W){immI[IMM_I_W-1]}}, immI};
		OP_LOAD, OP_LDB, OP_JSR:
			imm = {{(IMM_WIDTH-IMM_I_W){immI[IMM_I_W-1]}}, immI};
		// A shift amount is never negative
		OP_SHIFT:
			imm = {{(IMM_WIDTH-SHAMT_W){1'b0}}, shamt};
		// CSR number, privilege bits included, is unsigned
		OP_CSR:
			imm = {{(IMM_WIDTH-IMM_I_W){1'b0}}, immI};
		OP_STORE:
			imm = {{(IMM_WIDTH-ST_W){immSt[ST_W-1]}}, immSt};
		OP_BSR:
			imm = {{(IMM_WIDTH-DISP_W){disp[DISP_W-1]}}, disp};
		// NOP, RR, FLT and illegal encodings carry no immediate
		default:
			imm = '0;
		endcase
	end

endmodule

`default_nettype wire

/* rtl/decodePkg.sv */
// ==================================================
// Encodings are local to this decode slice. Opcodes not listed in
// opcodeT decode as illegal. Field positions assume a 32-bit micro-op
// ==================================================
`default_nettype none

package decodePkg;

	// ==================================================
	// Widths and constants
	// ==================================================

	localparam int OPC_WIDTH = 7;
	localparam int AREG_WIDTH = 7;
	localparam int IMM_WIDTH = 64;

	// Valid flags as the rename stage reads them
	localparam logic VAL = 1'b1;
	localparam logic INV = 1'b0;

	// Bit positions of the immediate fields inside the micro-op
	localparam int IMM_I_MSB = 31;
	localparam int IMM_I_LSB = 21;
	localparam int SHAMT_MSB = 26;
	localparam int ST_HI_LSB = 28;
	localparam int DISP_LSB = 14;
	// The CSR privilege level sits in immediate bits 10 to 9
	localparam int CSR_PRIV_LSB = 30;
	// Link-write bit inside the rd field for CSR and branch-and-link
	localparam int RD_LINK_BIT = 5;

	// Widths of the raw immediate fields before extension
	localparam int IMM_I_W = IMM_I_MSB - IMM_I_LSB + 1;
	localparam int SHAMT_W = SHAMT_MSB - IMM_I_LSB + 1;
	localparam int ST_W = (IMM_I_MSB - ST_HI_LSB + 1) + AREG_WIDTH;
	localparam int DISP_W = IMM_I_MSB - DISP_LSB + 1;

	typedef logic [AREG_WIDTH-1:0] aregNoT;

	// ==================================================
	// Enumerations
	// ==================================================

	typedef enum logic [OPC_WIDTH-1:0] {
		OP_NOP   = 7'h00,
		OP_ADDI  = 7'h04,
		OP_SUBFI = 7'h05,
		OP_CMPI  = 7'h06,
		OP_ANDI  = 7'h08,
		OP_ORI   = 7'h09,
		OP_XORI  = 7'h0A,
		OP_MULI  = 7'h0C,
		OP_SHIFT = 7'h10,
		OP_RR    = 7'h11,
		OP_FLT   = 7'h14,
		OP_LOAD  = 7'h20,
		OP_LDB   = 7'h21,
		OP_STORE = 7'h28,
		OP_CSR   = 7'h30,
		OP_BSR   = 7'h38,
		OP_JSR   = 7'h39
	} opcodeT;

	// Ordered so that a higher value means more privilege
	typedef enum logic [1:0] {
		OM_USER    = 2'd0,
		OM_SUPER   = 2'd1,
		OM_HYPER   = 2'd2,
		OM_MACHINE = 2'd3
	} operatingModeT;

	typedef enum logic [1:0] {
		EXC_NONE    = 2'd0,
		EXC_ILLEGAL = 2'd1,
		EXC_PRIV    = 2'd2
	} excCauseT;

	// ==================================================
	// Records
	// ==================================================

	// The I-format immediate overlays immHi and rs2, bits 31 to 21
	typedef struct packed {
		logic [3:0] immHi;
		aregNoT rs2;
		aregNoT rs1;
		aregNoT rd;
		opcodeT opcode;
	} microOpT;

	typedef struct packed {
		opcodeT opcode;
		aregNoT rd;
		logic rdv;
		aregNoT rs1;
		logic rs1v;
		aregNoT rs2;
		logic rs2v;
		logic [IMM_WIDTH-1:0] imm;
		excCauseT exc;
	} decodedOpT;

endpackage

`default_nettype wire

/* rtl/decodeRd.sv */
// ==================================================
// Purely combinational. The CSR privilege check trusts om to be
// the mode the micro-op will execute in
// ==================================================
`timescale 1ns/10ps
`default_nettype none

module decodeRd
	import decodePkg::*;
(
	input  microOpT       instr,
	input  operatingModeT om,
	output aregNoT        rd,
	output logic          rdv,
	output excCauseT      exc
);

	// Required privilege level encoded in the CSR immediate
	logic [1:0] csrPriv;

	assign csrPriv = instr[IMM_I_MSB:CSR_PRIV_LSB];

	// ==================================================
	// Destination and exception decode
	// ==================================================

	always_comb
	begin
		// Nothing is written unless an opcode below says otherwise
		rd = '0;
		rdv = INV;
		exc = EXC_NONE;
		case (instr.opcode)
		// ALU operations with an immediate always write rd
		OP_ADDI, OP_SUBFI, OP_CMPI, OP_ANDI, OP_ORI, OP_XORI, OP_MULI:
		begin
			rd = instr.rd;
			rdv = VAL;
		end
		// Shifts, register-register and float ops also always write
		OP_SHIFT, OP_RR, OP_FLT:
		begin
			rd = instr.rd;
			rdv = VAL;
		end
		OP_LOAD, OP_LDB:
		begin
			rd = instr.rd;
			rdv = VAL;
		end
		// A CSR access reads the old value into rd only when bit 5 asks for it
		OP_CSR:
		begin
			rd = instr.rd;
			if (csrPriv > om)
			begin
				// Too little privilege, so the old CSR value must not leak out
				exc = EXC_PRIV;
				rdv = INV;
			end
			else
			begin
				rdv = instr.rd[RD_LINK_BIT];
			end
		end
		// Branch-and-link writes the return address only if bit 5 is set
		OP_BSR, OP_JSR:
		begin
			rd = instr.rd;
			rdv = instr.rd[RD_LINK_BIT];
		end
		// Legal, but no destination
		OP_NOP, OP_STORE:
		begin
			rd = '0;
			rdv = INV;
		end
		// Any encoding outside opcodeT traps
		default:
		begin
			exc = EXC_ILLEGAL;
		end
		endcase
	end

endmodule

`default_nettype wire

/* rtl/decodeSources.sv */
// ==================================================
// Purely combinational. Unused source fields are zeroed
// ==================================================
`timescale 1ns/10ps
`default_nettype none

module decodeSources
	import decodePkg::*;
(
	input  microOpT instr,
	output aregNoT  rs1,
	output logic    rs1v,
	output aregNoT  rs2,
	output logic    rs2v
);

	// ==================================================
	// Which fields are real register reads
	// ==================================================

	always_comb
	begin
		rs1v = INV;
		rs2v = INV;
		case (instr.opcode)
		// Immediate ALU forms read only the first source
		OP_ADDI, OP_SUBFI, OP_CMPI, OP_ANDI, OP_ORI, OP_XORI, OP_MULI:
			rs1v = VAL;
		// Shift amount comes from the immediate, not from rs2
		OP_SHIFT:
			rs1v = VAL;
		OP_RR, OP_FLT:
		begin
			rs1v = VAL;
			rs2v = VAL;
		end
		// Loads use rs1 as the base address
		OP_LOAD, OP_LDB:
			rs1v = VAL;
		// Stores need a base in rs1 and the data in rs2
		OP_STORE:
		begin
			rs1v = VAL;
			rs2v = VAL;
		end
		// CSR writes take their value from rs1
		OP_CSR:
			rs1v = VAL;
		// JSR jumps through rs1, BSR is PC-relative
		OP_JSR:
			rs1v = VAL;
		// NOP, BSR and illegal encodings read nothing
		default:
		begin
			rs1v = INV;
			rs2v = INV;
		end
		endcase
	end

	// A field nobody reads is reported as register 0 so that rename
	// does not wait on a false dependency
	assign rs1 = rs1v ? instr.rs1 : '0;
	assign rs2 = rs2v ? instr.rs2 : '0;

endmodule

`default_nettype wire

/* rtl/decodeStage.sv */
// ==================================================
// One-cycle latency, one micro-op per cycle, no back-pressure.
// The consumer must take every record while decValid is high
// ==================================================
`timescale 1ns/10ps
`default_nettype none

module decodeStage
	import decodePkg::*;
(
	input  wire           clk,
	input  wire           rstN,
	input  wire           instrValid,
	input  microOpT       instr,
	input  operatingModeT om,
	output logic          decValid,
	output decodedOpT     dec
);

	// ==================================================
	// Field decoders, all combinational and in parallel
	// ==================================================

	aregNoT rd;
	logic rdv;
	excCauseT exc;
	aregNoT rs1;
	logic rs1v;
	aregNoT rs2;
	logic rs2v;
	logic [IMM_WIDTH-1:0] imm;

	// Record assembled ahead of the output register
	decodedOpT decNext;

	decodeRd decodeRd_inst (
		.instr(instr),
		.om(om),
		.rd(rd),
		.rdv(rdv),
		.exc(exc)
	);

	decodeSources decodeSources_inst (
		.instr(instr),
		.rs1(rs1),
		.rs1v(rs1v),
		.rs2(rs2),
		.rs2v(rs2v)
	);

	decodeImmediate decodeImmediate_inst (
		.instr(instr),
		.imm(imm)
	);

	always_comb
	begin
		decNext.opcode = instr.opcode;
		decNext.rd = rd;
		decNext.rdv = rdv;
		decNext.rs1 = rs1;
		decNext.rs1v = rs1v;
		decNext.rs2 = rs2;
		decNext.rs2v = rs2v;
		decNext.imm = imm;
		decNext.exc = exc;
	end

	// ==================================================
	// Output register
	// ==================================================

	// decValid follows the strobe by one cycle while dec keeps the
	// last record through idle cycles
	always_ff @(posedge clk, negedge rstN)
	begin
		if (!rstN)
		begin
			decValid <= 1'b0;
			dec <= '0;
		end
		else
		begin
			decValid <= instrValid;
			if (instrValid)
				dec <= decNext;
		end
	end

endmodule

`default_nettype wire

/* sim/decodeStageTb.sv */
// ==================================================
// Stimulus comes from a 32-bit Galois LFSR, so each run replays
// the same micro-op sequence
// ==================================================
`timescale 1ns/10ps
`default_nettype none

module decodeStageTb
	import decodePkg::*;
();

	localparam int RANDOM_OPS = 400;
	localparam int DRAIN_TIMEOUT = 20;

	// Starts low so that time zero carries no clock edge
	logic clk = 1'b0;
	logic rstN;
	logic instrValid;
	microOpT instr;
	operatingModeT om;
	logic decValid;
	decodedOpT dec;

	// Strobe as the DUT saw it at the last edge
	logic prevValid;
	logic [31:0] lfsrState;
	decodedOpT expQ[$];
	int checkCount;
	int mismatchCount;
	int orphanCount;
	int timeoutCount;

	opcodeT legalOps [17] = '{OP_NOP, OP_ADDI, OP_SUBFI, OP_CMPI, OP_ANDI, OP_ORI,
		OP_XORI, OP_MULI, OP_SHIFT, OP_RR, OP_FLT, OP_LOAD, OP_LDB, OP_STORE,
		OP_CSR, OP_BSR, OP_JSR};

	always #10 clk = ~clk;

	decodeStage decodeStage_inst (
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.instr(instr),
		.om(om),
		.decValid(decValid),
		.dec(dec)
	);

	// ==================================================
	// Random source and reference model
	// ==================================================

	// Right-shifting Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		else
			return s >> 1;
	endfunction

	// One LFSR step per bit handed out
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsrState = lfsrStep(lfsrState);
			v = {v[30:0], lfsrState[0]};
		end
		return v;
	endfunction

	function automatic decodedOpT expectedRecord(input microOpT w, input operatingModeT m);
		decodedOpT r;
		logic [10:0] immI;
		r = '0;
		r.opcode = w.opcode;
		immI = w[31:21];
		case (w.opcode)
		OP_ADDI, OP_SUBFI, OP_CMPI, OP_ANDI, OP_ORI, OP_XORI, OP_MULI,
		OP_LOAD, OP_LDB, OP_SHIFT:
		begin
			r.rdv = VAL;
			r.rs1v = VAL;
			// Shift amount is the low six bits of the field, never signed
			r.imm = (w.opcode == OP_SHIFT) ? {58'd0, immI[5:0]} : {{53{immI[10]}}, immI};
		end
		OP_RR, OP_FLT:
		begin
			r.rdv = VAL;
			r.rs1v = VAL;
			r.rs2v = VAL;
		end
		OP_STORE:
		begin
			r.rs1v = VAL;
			r.rs2v = VAL;
			r.imm = {{53{w[31]}}, w[31:28], w[13:7]};
		end
		// Privilege field sits in the top two immediate bits
		OP_CSR:
		begin
			r.rs1v = VAL;
			r.imm = {53'd0, immI};
			r.rdv = (w[31:30] > m) ? INV : w.rd[5];
			r.exc = (w[31:30] > m) ? EXC_PRIV : EXC_NONE;
		end
		OP_BSR:
		begin
			r.rdv = w.rd[5];
			r.imm = {{46{w[31]}}, w[31:14]};
		end
		OP_JSR:
		begin
			r.rdv = w.rd[5];
			r.rs1v = VAL;
			r.imm = {{53{immI[10]}}, immI};
		end
		OP_NOP:
			r.rdv = INV;
		default:
			r.exc = EXC_ILLEGAL;
		endcase
		// Only NOP, store and illegal encodings leave rd at zero
		if (w.opcode != OP_NOP && w.opcode != OP_STORE && r.exc != EXC_ILLEGAL)
			r.rd = w.rd;
		r.rs1 = r.rs1v ? w.rs1 : '0;
		r.rs2 = r.rs2v ? w.rs2 : '0;
		return r;
	endfunction

	// ==================================================
	// Drive and check helpers
	// ==================================================

	task automatic checkField(input string name, input logic [63:0] expV,
		input logic [63:0] gotV);
		checkCount++;
		assert (gotV === expV)
		else
		begin
			$display("CHECK FAILED at %0t: %s expected %0h, got %0h", $time, name, expV, gotV);
			mismatchCount++;
		end
	endtask

	task automatic checkResetState();
		checkCount++;
		assert (decValid === 1'b0 && dec === '0)
		else
		begin
			$display("CHECK FAILED at %0t: reset state wrong, decValid %0b dec %0h",
				$time, decValid, dec);
			mismatchCount++;
		end
	endtask

	// The model result is queued when the strobe goes out
	task automatic driveOp(input microOpT w, input operatingModeT m, input logic v);
		@(posedge clk);
		instrValid <= v;
		instr <= w;
		om <= m;
		if (v)
			expQ.push_back(expectedRecord(w, m));
	endtask

	always @(posedge clk, negedge rstN)
	begin
		if (!rstN)
			prevValid <= 1'b0;
		else
			prevValid <= instrValid;
	end

	// Outputs are sampled at the falling edge, well away from the update
	always @(negedge clk)
	begin
		decodedOpT want;
		if (!rstN)
			checkResetState();
		else
		begin
			checkField("decValid", prevValid, decValid);
			if (decValid && expQ.size() == 0)
			begin
				$display("Record at %0t arrived with no micro-op pending", $time);
				orphanCount++;
			end
			else if (decValid)
			begin
				want = expQ.pop_front();
				checkField("opcode", want.opcode, dec.opcode);
				checkField("rd", want.rd, dec.rd);
				checkField("rdv", want.rdv, dec.rdv);
				checkField("rs1", want.rs1, dec.rs1);
				checkField("rs1v", want.rs1v, dec.rs1v);
				checkField("rs2", want.rs2, dec.rs2);
				checkField("rs2v", want.rs2v, dec.rs2v);
				checkField("imm", want.imm, dec.imm);
				checkField("exc", want.exc, dec.exc);
			end
		end
	end

	// ==================================================
	// Test sequence
	// ==================================================

	initial
	begin
		microOpT w;
		logic [6:0] rawOp;
		logic [1:0] rawMode;
		int drainWait;
		rstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		om = OM_USER;
		lfsrState = 32'h780;
		checkCount = 0;
		mismatchCount = 0;
		orphanCount = 0;
		timeoutCount = 0;
		repeat (3) @(posedge clk);
		rstN <= 1'b1;
		@(negedge clk);
		checkResetState();

		// Half legal opcodes, half raw 7-bit values that are mostly illegal
		for (int n = 0; n < RANDOM_OPS; n++)
		begin
			w = microOpT'(randBits(32));
			if (randBits(1))
				w.opcode = legalOps[randBits(5) % 17];
			else
			begin
				rawOp = 7'(randBits(7));
				w.opcode = opcodeT'(rawOp);
			end
			rawMode = 2'(randBits(2));
			driveOp(w, operatingModeT'(rawMode), randBits(2) != 0);
		end

		// Every CSR privilege field against every mode, back to back
		for (int p = 0; p < 4; p++)
		begin
			for (int k = 0; k < 4; k++)
			begin
				w = microOpT'(randBits(32));
				w.opcode = OP_CSR;
				w[31:30] = p[1:0];
				driveOp(w, operatingModeT'(k[1:0]), 1'b1);
			end
		end
		driveOp('0, OM_USER, 1'b0);

		drainWait = 0;
		while (expQ.size() != 0 && drainWait < DRAIN_TIMEOUT)
		begin
			@(negedge clk);
			drainWait++;
		end
		if (expQ.size() != 0)
		begin
			$display("Timeout at %0t: %0d decoded records never arrived", $time, expQ.size());
			timeoutCount++;
		end

		$display("Checks: %0d, mismatches: %0d, unexpected records: %0d, timeouts: %0d",
			checkCount, mismatchCount, orphanCount, timeoutCount);
		if (mismatchCount + orphanCount + timeoutCount == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

/* sim/decodeStage_props.sv */
// ==================================================
// Bound into every decodeStage. Checks run on the rising clock edge
// ==================================================
`timescale 1ns/10ps
`default_nettype none

module decodeStageProps
	import decodePkg::*;
(
	input wire       clk,
	input wire       rstN,
	input wire       instrValid,
	input wire       decValid,
	input decodedOpT dec
);

	// The output register is cleared for as long as reset is held
	resetClears: assert property (@(posedge clk) !rstN |-> !decValid)
		else $error("decValid high during reset");

	// Exactly one cycle from strobe to record
	oneCycleLatency: assert property (@(posedge clk) disable iff (!rstN)
		$past(rstN) |-> (decValid == $past(instrValid)))
		else $error("decValid does not follow instrValid by one cycle");

	// An illegal opcode never writes a register
	illegalNoWrite: assert property (@(posedge clk) disable iff (!rstN)
		dec.exc == EXC_ILLEGAL |-> dec.rdv != VAL)
		else $error("illegal opcode reports a valid destination");

	// Sources that are not read show up as register 0
	rs1Zeroed: assert property (@(posedge clk) disable iff (!rstN)
		!dec.rs1v |-> dec.rs1 == '0)
		else $error("rs1 not zero while rs1v is clear");

	rs2Zeroed: assert property (@(posedge clk) disable iff (!rstN)
		!dec.rs2v |-> dec.rs2 == '0)
		else $error("rs2 not zero while rs2v is clear");

endmodule

bind decodeStage decodeStageProps decodeStageProps_inst (
	.clk(clk),
	.rstN(rstN),
	.instrValid(instrValid),
	.decValid(decValid),
	.dec(dec)
);

`default_nettype wire
